//--- include/thor_consts.svh
// Fixed widths of the 48-bit instruction format
// The NOP word stands in as the postfix of an instruction that has none
`ifndef THOR_CONSTS_SVH
`define THOR_CONSTS_SVH

// ========================================
// Word widths
// ========================================

// One instruction word
`define THOR_INSN_W 48

// Operand and immediate value
`define THOR_VALUE_W 64

// Register number
`define THOR_REG_W 6

// ========================================
// Fixed words
// ========================================

// Opcode in the low byte, all other fields zero
`define THOR_NOP_WORD 48'h0000_0000_00F1

`endif

//--- verilog/thor_pkg.sv
// Types and encodings for the kept subset of the instruction set only
// Vector, float, CSR, segment and loop-counter fields are not represented
`include "thor_consts.svh"

package thor_pkg;

	typedef logic [`THOR_INSN_W-1:0] insn_t;
	typedef logic [`THOR_VALUE_W-1:0] value_t;
	typedef logic [`THOR_REG_W-1:0] regno_t;
	typedef logic [7:0] opcode_t;
	typedef logic [5:0] func_t;
	typedef logic [2:0] cat_t;

	// ========================================
	// Opcodes, bits 7:0 of a word
	// ========================================
	localparam opcode_t R2    = 8'h02;
	localparam opcode_t ADDI  = 8'h04;
	localparam opcode_t ANDI  = 8'h08;
	localparam opcode_t ORI   = 8'h09;
	localparam opcode_t ADDIL = 8'h14;
	localparam opcode_t ANDIL = 8'h18;
	localparam opcode_t ORIL  = 8'h19;
	localparam opcode_t JMP   = 8'h20;
	localparam opcode_t JEQ   = 8'h26;
	localparam opcode_t JNE   = 8'h27;
	// Postfixes carry extra immediate bits for the instruction before them
	localparam opcode_t EXI7  = 8'h50;
	localparam opcode_t EXI23 = 8'h51;
	localparam opcode_t EXI41 = 8'h52;
	localparam opcode_t LDB   = 8'h80;
	localparam opcode_t LDBU  = 8'h81;
	localparam opcode_t LDW   = 8'h82;
	localparam opcode_t LDWU  = 8'h83;
	localparam opcode_t LDO   = 8'h86;
	localparam opcode_t STB   = 8'h90;
	localparam opcode_t STW   = 8'h91;
	localparam opcode_t STO   = 8'h93;
	// Same byte as the NOP word
	localparam opcode_t NOP   = opcode_t'(`THOR_NOP_WORD);

	// R2 function codes, bits 47:42
	localparam func_t ADD = 6'h04;
	localparam func_t MUL = 6'h08;
	localparam func_t DIV = 6'h10;

	typedef enum logic [1:0] {byt = 2'd0, wyde = 2'd1, tetra = 2'd2, octa = 2'd3} mem_size_t;

	typedef enum logic {JOIN_EMPTY, JOIN_HOLD} join_state_t;

	// Instruction with its postfix, or the NOP word when it has none
	typedef struct packed {
		insn_t ir;
		insn_t xir;
	} insn_pair_t;

	typedef struct packed {
		regno_t ra;
		regno_t rb;
		regno_t rc;
		regno_t rt;
		logic rfwr;
		value_t imm;
		mem_size_t memsz;
		logic ld;
		logic ldz;
		logic st;
		logic jmp;
		logic jxx;
		logic mul;
		logic div;
		logic multi_cycle;
		logic carfwr;
		cat_t cat;
		value_t jmptgt;
	} deco_t;

endpackage

//--- verilog/thor_postfix_joiner.sv
// Holds one instruction until the next word or a flush shows its postfix
// A flush with a word that displaces a held instruction acts one cycle later
`timescale 1ns/1ps
`include "thor_consts.svh"

module thor_postfix_joiner import thor_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input insn_t word,
	input logic word_valid,
	input logic flush,
	output insn_pair_t pair,
	output logic pair_valid,
	output logic orphan_postfix
);

join_state_t state;
join_state_t state_nxt;
insn_t hold_ir;
insn_pair_t pair_nxt;
logic is_postfix;
logic flush_req;
logic flush_pend;
logic pend_nxt;
logic emit;
logic orphan;

assign is_postfix = word[7:0] inside {EXI7, EXI23, EXI41};
// Flush left over from a word that replaced the held instruction
assign flush_req = flush | flush_pend;

// The word is taken first, then the flush acts on what is held
always_comb
begin
	state_nxt = state;
	emit = 1'b0;
	orphan = 1'b0;
	pend_nxt = 1'b0;
	pair_nxt.ir = hold_ir;
	pair_nxt.xir = `THOR_NOP_WORD;
	case (state)
	JOIN_EMPTY:
		if (word_valid)
		begin
			if (is_postfix)
				orphan = 1'b1;
			else if (flush_req)
			begin
				emit = 1'b1;
				pair_nxt.ir = word;
			end
			else
				state_nxt = JOIN_HOLD;
		end
	JOIN_HOLD:
		if (word_valid && is_postfix)
		begin
			emit = 1'b1;
			pair_nxt.xir = word;
			state_nxt = JOIN_EMPTY;
		end
		else if (word_valid)
		begin
			// Held one goes out bare, the new word takes its place
			emit = 1'b1;
			pend_nxt = flush_req;
		end
		else if (flush_req)
		begin
			emit = 1'b1;
			state_nxt = JOIN_EMPTY;
		end
	default:	state_nxt = JOIN_EMPTY;
	endcase
end

always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
	begin
		state <= JOIN_EMPTY;
		pair_valid <= 1'b0;
		orphan_postfix <= 1'b0;
		flush_pend <= 1'b0;
	end
	else
	begin
		state <= state_nxt;
		pair_valid <= emit;
		orphan_postfix <= orphan;
		flush_pend <= pend_nxt;
	end
end

always_ff @(posedge clk)
begin
	if (word_valid && !is_postfix)
		hold_ir <= word;
	if (emit)
		pair <= pair_nxt;
end

endmodule

//--- verilog/thor_decoder.sv
// Combinational decode of one instruction and its postfix for the kept subset
// Opcodes outside the subset decode as a no-op with a zero immediate
`timescale 1ns/1ps

module thor_decoder import thor_pkg::*;
(
	input insn_pair_t pair,
	output deco_t deco
);

insn_t ir;
insn_t xir;
opcode_t opc;
opcode_t xopc;
func_t func;
logic is_load;
logic is_store;
logic is_jump;
logic is_mul;
logic is_div;

assign ir = pair.ir;
assign xir = pair.xir;
assign opc = ir[7:0];
assign xopc = xir[7:0];
assign func = ir[47:42];

always_comb
begin
	// ========================================
	// Instruction groups
	// ========================================
	is_load = opc inside {LDB, LDBU, LDW, LDWU, LDO};
	is_store = opc inside {STB, STW, STO};
	is_jump = opc inside {JMP, JEQ, JNE};
	is_mul = (opc == R2) && (func == MUL);
	is_div = (opc == R2) && (func == DIV);

	// ========================================
	// Register fields
	// ========================================
	deco.ra = ir[20:15];
	deco.rb = ir[26:21];
	// Stores name their source in the target slot
	deco.rc = is_store ? ir[14:9] : ir[34:29];
	// Jumps write only the link registers
	deco.rt = is_jump ? {4'd0, ir[10:9]} : ir[14:9];

	case (opc)
	R2:
		case (func)
		ADD, MUL, DIV:	deco.rfwr = 1'b1;
		default:	deco.rfwr = 1'b0;
		endcase
	ADDI, ANDI, ORI:	deco.rfwr = 1'b1;
	ADDIL, ANDIL, ORIL:	deco.rfwr = 1'b1;
	LDB, LDBU, LDW, LDWU, LDO:	deco.rfwr = 1'b1;
	default:	deco.rfwr = 1'b0;
	endcase

	// ========================================
	// Immediate
	// ========================================
	case (opc)
	ADDI:	deco.imm = {{53{ir[31]}}, ir[31:21]};
	// AND masks keep the upper bits
	ANDI:	deco.imm = {{53{1'b1}}, ir[31:21]};
	ORI:	deco.imm = {{53{1'b0}}, ir[31:21]};
	ADDIL:	deco.imm = {{41{ir[43]}}, ir[43:21]};
	ANDIL:	deco.imm = {{41{1'b1}}, ir[43:21]};
	ORIL:	deco.imm = {{41{1'b0}}, ir[43:21]};
	LDB, LDBU, LDW, LDWU, LDO, STB, STW, STO:
		deco.imm = {{40{ir[47]}}, ir[47:24]};
	default:	deco.imm = '0;
	endcase
	// A postfix extends the long field above and, for EXI41, below
	case (xopc)
	EXI7:	deco.imm = {{34{xir[15]}}, xir[15:9], ir[43:21]};
	EXI23:	deco.imm = {{18{xir[31]}}, xir[31:9], ir[43:21]};
	EXI41:	deco.imm = {xir[47:9], ir[43:21], xir[1:0]};
	default:	;
	endcase

	// Memory access
	deco.ld = is_load;
	deco.ldz = opc inside {LDBU, LDWU};
	deco.st = is_store;
	case (opc)
	LDB, LDBU, STB:	deco.memsz = byt;
	LDW, LDWU, STW:	deco.memsz = wyde;
	default:	deco.memsz = octa;
	endcase

	deco.mul = is_mul;
	deco.div = is_div;
	deco.multi_cycle = is_mul | is_div | is_load | is_store;

	// ========================================
	// Jumps
	// ========================================
	deco.jmp = (opc == JMP);
	deco.jxx = opc inside {JEQ, JNE};
	// Link field zero means no link register write
	deco.carfwr = is_jump && (ir[10:9] != 2'd0);
	deco.cat = is_jump ? {1'b0, ir[10:9]} : 3'd0;
	// Target counts half-words
	deco.jmptgt = {{32{ir[47]}}, ir[47:17], 1'b0};
end

endmodule

//--- verilog/thor_decode_top.sv
// Decode stage: postfix joiner, decoder and one output register
// No stall input, every record leaves one cycle after its pair
`timescale 1ns/1ps

module thor_decode_top import thor_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input insn_t word,
	input logic word_valid,
	input logic flush,
	output deco_t deco,
	output logic deco_valid,
	output logic orphan_postfix
);

insn_pair_t pair;
logic pair_valid;
deco_t deco_nxt;

thor_postfix_joiner i_thor_postfix_joiner
(
	.clk(clk),
	.arst_n(arst_n),
	.word(word),
	.word_valid(word_valid),
	.flush(flush),
	.pair(pair),
	.pair_valid(pair_valid),
	.orphan_postfix(orphan_postfix)
);

thor_decoder i_thor_decoder
(
	.pair(pair),
	.deco(deco_nxt)
);

// ========================================
// Output register
// ========================================
always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
		deco_valid <= 1'b0;
	else
		deco_valid <= pair_valid;
end

// Record only changes with a new pair
always_ff @(posedge clk)
begin
	if (pair_valid)
		deco <= deco_nxt;
end

endmodule

//--- sim/thor_clock_gen.sv
// Free-running clock of 20 ns, reset held low for the first 10 cycles
`timescale 1ns/1ps

module thor_clock_gen
(
	output logic clk,
	output logic arst_n
);

initial
begin
	clk = 1'b0;
	forever #10 clk = ~clk;
end

// Release away from the rising edge
initial
begin
	arst_n = 1'b0;
	repeat (10) @(posedge clk);
	@(negedge clk);
	arst_n = 1'b1;
end

endmodule

//--- sim/thor_decode_checker.sv
// Bound into the decode top, sees the joiner strobe through the top's own net
`timescale 1ns/1ps

module thor_decode_checker
(
	input logic clk,
	input logic arst_n,
	input logic pair_valid,
	input logic deco_valid,
	input logic orphan_postfix
);

int fail_count = 0;

// Output register adds exactly one cycle
valid_follows_pair: assert property (@(posedge clk) disable iff (!arst_n)
	deco_valid == $past(pair_valid))
else
begin
	fail_count++;
	$error("deco_valid does not follow pair_valid by one cycle");
end

pair_not_orphan: assert property (@(posedge clk) disable iff (!arst_n)
	!(pair_valid && orphan_postfix))
else
begin
	fail_count++;
	$error("pair_valid and orphan_postfix high together");
end

strobes_low_in_reset: assert property (@(posedge clk)
	!arst_n |-> !(pair_valid || deco_valid || orphan_postfix))
else
begin
	fail_count++;
	$error("strobe high while arst_n is low");
end

endmodule

bind thor_decode_top thor_decode_checker i_thor_decode_checker
(
	.clk(clk),
	.arst_n(arst_n),
	.pair_valid(pair_valid),
	.deco_valid(deco_valid),
	.orphan_postfix(orphan_postfix)
);

//--- sim/tb_thor_decode.sv
// Run from the project root since the tests file path is relative to it
// Records are compared in file order at each deco_valid
`timescale 1ns/1ps

module tb_thor_decode import thor_pkg::*;
();

localparam int PERIOD_NS = 20;

logic clk;
logic arst_n;
insn_t word;
logic word_valid;
logic flush;
deco_t deco;
logic deco_valid;
logic orphan_postfix;

byte act_kind[$];
insn_t act_word[$];
deco_t exp_q[$];
int exp_total = 0;
int exp_orphans = 0;
int file_lines = 0;
logic opened;
logic loaded = 1'b0;
logic seen_word = 1'b0;
int value_errors = 0;
int records = 0;
int orphans = 0;

thor_clock_gen i_thor_clock_gen
(
	.clk(clk),
	.arst_n(arst_n)
);

thor_decode_top i_thor_decode_top
(
	.clk(clk),
	.arst_n(arst_n),
	.word(word),
	.word_valid(word_valid),
	.flush(flush),
	.deco(deco),
	.deco_valid(deco_valid),
	.orphan_postfix(orphan_postfix)
);

// ========================================
// Checks
// ========================================
task automatic check_deco(deco_t got, deco_t exp);
	if (got !== exp)
	begin
		value_errors++;
		$display("error at %0d ns: deco got %h expected %h", $time, got, exp);
	end
endtask

task automatic check_records(int got, int exp);
	if (got != exp)
	begin
		value_errors++;
		$display("error at %0d ns: deco_valid count got %0d expected %0d", $time, got, exp);
	end
endtask

task automatic check_orphans(int got, int exp);
	if (got != exp)
	begin
		value_errors++;
		$display("error at %0d ns: orphan_postfix count got %0d expected %0d", $time, got, exp);
	end
endtask

task automatic fail_run(string why);
	$display("%s", why);
	$display("sim failed");
	$finish;
endtask

// ========================================
// Tests file
// ========================================
task automatic load_tests(output logic ok);
	int fd;
	int n;
	string line;
	string kind;
	insn_t w;
	deco_t rec;
	logic [63:0] f [18];
	fd = $fopen("sim/thor_decode_tests.txt", "r");
	ok = (fd != 0);
	if (ok)
	begin
		while (!$feof(fd))
		begin
			line = "";
			kind = "";
			n = $fgets(line, fd);
			if (n > 0)
				file_lines++;
			n = $sscanf(line, "%s", kind);
			if (kind == "w")
			begin
				n = $sscanf(line, "w %h", w);
				act_kind.push_back("w");
				act_word.push_back(w);
			end
			else if (kind == "f" || kind == "i")
			begin
				act_kind.push_back(kind[0]);
				act_word.push_back('0);
			end
			else if (kind == "o")
				n = $sscanf(line, "o %d", exp_orphans);
			else if (kind == "e")
			begin
				n = $sscanf(line, "e %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
					f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
				rec = '{ra: regno_t'(f[0]), rb: regno_t'(f[1]),
					rc: regno_t'(f[2]), rt: regno_t'(f[3]), rfwr: f[4][0],
					imm: value_t'(f[5]), memsz: mem_size_t'(f[6][1:0]),
					ld: f[7][0], ldz: f[8][0], st: f[9][0], jmp: f[10][0],
					jxx: f[11][0], mul: f[12][0], div: f[13][0],
					multi_cycle: f[14][0], carfwr: f[15][0], cat: cat_t'(f[16]),
					jmptgt: value_t'(f[17])};
				exp_q.push_back(rec);
			end
		end
		$fclose(fd);
	end
endtask

// One file action per falling edge
task automatic drive_actions();
	for (int i = 0; i < act_kind.size(); i++)
	begin
		@(negedge clk);
		word_valid = (act_kind[i] == "w");
		word = act_word[i];
		flush = (act_kind[i] == "f");
	end
	@(negedge clk);
	word_valid = 1'b0;
	flush = 1'b0;
endtask

always @(posedge clk)
	if (word_valid)
		seen_word = 1'b1;

always @(negedge clk)
begin
	if (arst_n && deco_valid)
	begin
		records++;
		if (!seen_word)
		begin
			value_errors++;
			$display("deco_valid came before any word was driven");
		end
		else if (exp_q.size() == 0)
		begin
			value_errors++;
			$display("deco_valid came with no expected record left");
		end
		else
			check_deco(deco, exp_q.pop_front());
	end
	if (arst_n && orphan_postfix)
		orphans++;
end

initial
begin
	word = '0;
	word_valid = 1'b0;
	flush = 1'b0;
	load_tests(opened);
	if (!opened)
		fail_run("cannot open sim/thor_decode_tests.txt");
	else
	begin
		exp_total = exp_q.size();
		loaded = 1'b1;
		wait (arst_n === 1'b1);
		repeat (3) @(negedge clk);
		drive_actions();
		wait (records >= exp_total);
		// Room for a stray record
		repeat (4) @(negedge clk);
		check_records(records, exp_total);
		check_orphans(orphans, exp_orphans);
		$display("errors: %0d value, %0d assertion", value_errors,
			i_thor_decode_top.i_thor_decode_checker.fail_count);
		if (value_errors == 0 && i_thor_decode_top.i_thor_decode_checker.fail_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end
end

// Watchdog
initial
begin
	wait (loaded === 1'b1);
	#((file_lines * 4 + 20) * PERIOD_NS);
	fail_run("timeout: the watchdog expired before all records arrived");
end

endmodule

//--- all.f
+incdir+include
verilog/thor_pkg.sv
verilog/thor_postfix_joiner.sv
verilog/thor_decoder.sv
verilog/thor_decode_top.sv
sim/thor_clock_gen.sv
sim/thor_decode_checker.sv
sim/tb_thor_decode.sv

//--- Makefile
TOP = tb_thor_decode

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -f all.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim/thor_decode_tests.txt
# w <insn hex> drives a word, f a flush, i an idle cycle, o <n> the orphan_postfix total
# e ra rb rc rt rfwr imm memsz ld ldz st jmp jxx mul div multi_cycle carfwr cat jmptgt
w 100060408A02
e 1 2 3 5 1 0 3 0 0 0 0 0 0 0 0 0 0 10006040
w 200060408A02
e 1 2 3 5 1 0 3 0 0 0 0 0 1 0 1 0 0 20006040
w 400060408A02
e 1 2 3 5 1 0 3 0 0 0 0 0 0 1 1 0 0 40006040
w 000080008A04
e 1 0 4 5 1 FFFFFFFFFFFFFC00 3 0 0 0 0 0 0 0 0 0 0 8000
w 00001E008A08
e 1 30 0 5 1 FFFFFFFFFFFFF8F0 3 0 0 0 0 0 0 0 0 0 0 1E00
w 0000A0008A09
e 1 0 5 5 1 500 3 0 0 0 0 0 0 0 0 0 0 A000
f
w 080000008A14
e 1 0 0 5 1 FFFFFFFFFFC00000 3 0 0 0 0 0 0 0 0 0 0 8000000
w 000000208A18
w 000000008050
e 1 1 0 5 1 FFFFFFFFE0000001 3 0 0 0 0 0 0 0 0 0 0 20
w 000000008050
w 000002008A19
w 000000000651
e 1 10 0 5 1 1800010 3 0 0 0 0 0 0 0 0 0 0 200
w 000000408A14
w 000000000252
e 1 2 0 5 1 200000A 3 0 0 0 0 0 0 0 0 0 0 40
w 800000008A80
e 1 0 0 5 1 FFFFFFFFFF800000 0 1 0 0 0 0 0 0 1 0 0 FFFFFFFF80000000
w 000010008A83
e 1 0 0 5 1 10 1 1 1 0 0 0 0 0 1 0 0 1000
w 000001008A93
e 1 8 5 5 0 1 3 0 0 1 0 0 0 0 1 0 0 100
w 800000000020
e 0 0 0 0 0 0 3 0 0 0 1 0 0 0 0 0 0 FFFFFFFF80000000
w 000000208426
e 1 1 0 2 0 0 3 0 0 0 0 1 0 0 0 1 2 20
w 000000000E27
e 0 0 0 3 0 0 3 0 0 0 0 1 0 0 0 1 3 0
i
f
o 1
